// ==== sources.f ====
+incdir+verilog
verilog/trace_pkg.sv
verilog/instr_classifier.sv
verilog/trace_fifo.sv
verilog/stage_tracker.sv
verilog/trace_emitter.sv
verilog/trace_unit_top.sv
verification/tb_trace_unit.sv

// ==== verification/tb_trace_unit.sv ====
// trace unit testbench

`timescale 1ns/1ps

`include "trace_params.svh"

module tb_trace_unit import trace_pkg::*; ();

  localparam int N_CLASS    = 30;
  localparam int N_REGW     = 30;
  localparam int N_MEM      = 30;
  localparam int N_ROUNDS   = 4;
  localparam int BURST      = 6;
  localparam int OVF_ISSUES = 24;
  localparam int CAPACITY   = 11;
  localparam logic [31:0] OVF_BASE = 32'h0000_8000;
  // cycle budget per scripted item
  localparam int SINGLE_LEN = 30;
  localparam int BURST_LEN  = 150;
  localparam int OVF_LEN    = OVF_ISSUES + CAPACITY * 12 + 60;
  localparam int RESET_LEN  = 50 + SINGLE_LEN;
  localparam int TIMEOUT_CYCLES = 10 + (N_CLASS + N_REGW + N_MEM) * SINGLE_LEN
                                + N_ROUNDS * BURST_LEN + OVF_LEN + RESET_LEN + 200;

  logic        clk = 1'b0;
  logic        rst_n, id_valid, is_decoding, ex_valid, wb_bypass, wb_valid;
  logic        data_req, data_gnt, data_we, trace_ack, trace_req, overflow;
  logic [31:0] pc, instr, data_addr;
  reg_write_t  ex_wr, wb_wr;
  trace_rec_t  trace_rec;

  trace_rec_t  exp_q[$];
  logic [31:0] model_cyc;
  int          errors = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          issue_total = 0;
  int          first_drop = -1;
  int          emitted = 0;
  int          max_delay = 2;
  int          tb_cycles = 0;
  bit          ack_hold = 1'b0;
  bit          ovf_mode = 1'b0;

  trace_unit_top dut (
    .clk, .rst_n, .id_valid, .is_decoding, .pc, .instr, .ex_valid, .wb_bypass,
    .ex_wr, .data_req, .data_gnt, .data_we, .data_addr, .wb_valid, .wb_wr,
    .trace_ack, .trace_req, .trace_rec, .overflow
  );

  always #5 clk = ~clk;

  ////////////////////////////////////////
  // reference model

  function automatic instr_class_e class_of(input logic [6:0] opc);
    case (opc)
      `OPC_LUI, `OPC_AUIPC:         return cls_upper;
      `OPC_JAL, `OPC_JALR:          return cls_jump;
      `OPC_BRANCH:                  return cls_branch;
      `OPC_LOAD, `OPC_LOAD_POST:    return cls_load;
      `OPC_STORE, `OPC_STORE_POST:  return cls_store;
      `OPC_OPIMM:                   return cls_alu_imm;
      `OPC_OP:                      return cls_alu_reg;
      `OPC_SYSTEM:                  return cls_system;
      `OPC_CUSTOM_A, `OPC_CUSTOM_B: return cls_custom;
      default:                      return cls_invalid;
    endcase
  endfunction

  function automatic trace_rec_t expect_issue(input logic [31:0] p, input logic [31:0] ins,
                                              input logic [31:0] cyc);
    trace_rec_t r;
    r       = '0;
    r.pc    = p;
    r.instr = ins;
    r.cycle = cyc;
    r.cls   = class_of(ins[6:0]);
    r.rs1   = ins[19:15];
    if (r.cls != cls_branch && r.cls != cls_store) begin
      r.rd = ins[11:7];
    end
    if (r.cls inside {cls_branch, cls_store, cls_alu_reg, cls_custom}) begin
      r.rs2 = ins[24:20];
    end
    return r;
  endfunction

  // indices 14 and 15 give a random, mostly invalid opcode
  function automatic logic [6:0] pick_opcode(input int unsigned sel, input logic [6:0] rnd);
    case (sel % 16)
      0:       return `OPC_LUI;
      1:       return `OPC_AUIPC;
      2:       return `OPC_JAL;
      3:       return `OPC_JALR;
      4:       return `OPC_BRANCH;
      5:       return `OPC_LOAD;
      6:       return `OPC_STORE;
      7:       return `OPC_OPIMM;
      8:       return `OPC_OP;
      9:       return `OPC_SYSTEM;
      10:      return `OPC_LOAD_POST;
      11:      return `OPC_STORE_POST;
      12:      return `OPC_CUSTOM_A;
      13:      return `OPC_CUSTOM_B;
      default: return rnd;
    endcase
  endfunction

  function automatic reg_idx_t pick_addr(input reg_idx_t field);
    case ($urandom % 4)
      0:       return field;
      1:       return '0;
      default: return reg_idx_t'($urandom);
    endcase
  endfunction

  // last matching write wins, x0 never counts
  task automatic apply_write(input reg_write_t w, input reg_idx_t rd,
                             inout logic written, inout logic [31:0] value);
    if (w.we && rd != '0 && w.addr == rd) begin
      written = 1'b1;
      value   = w.data;
    end
  endtask

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      model_cyc <= '0;
    end else begin
      model_cyc <= model_cyc + 1'b1;
    end
  end

  // issue monitor, sees pre-edge values
  always @(posedge clk) begin
    if (rst_n) begin
      // overflow shows two edges after the dropped issue
      if (overflow && first_drop < 0) begin
        first_drop = issue_total - 2;
      end
      if (id_valid && is_decoding) begin
        exp_q.push_back(expect_issue(pc, instr, model_cyc));
        issue_total++;
      end
    end
  end

  ////////////////////////////////////////
  // checks and the trace port responder

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_record(input trace_rec_t got);
    trace_rec_t exp;
    int         idx;
    if (ovf_mode) begin
      // dropped issues may only follow the first drop
      while (exp_q.size() > 0 && exp_q[0].pc != got.pc) begin
        idx = issue_total - exp_q.size();
        if (first_drop < 0 || idx < first_drop) begin
          $display("issue %0d is missing from the trace before the first drop", idx);
          errors++;
        end
        void'(exp_q.pop_front());
      end
    end
    if (exp_q.size() == 0) begin
      $display("record with pc %h came out with no issued instruction pending", got.pc);
      errors++;
    end else begin
      exp = exp_q.pop_front();
      emitted++;
      check_field("pc", got.pc, exp.pc);
      check_field("instr", got.instr, exp.instr);
      check_field("cycle", got.cycle, exp.cycle);
      check_field("cls", got.cls, exp.cls);
      check_field("rd", got.rd, exp.rd);
      check_field("rs1", got.rs1, exp.rs1);
      check_field("rs2", got.rs2, exp.rs2);
      check_field("rd_written", got.rd_written, exp.rd_written);
      check_field("rd_value", got.rd_value, exp.rd_value);
      check_field("mem.valid", got.mem.valid, exp.mem.valid);
      check_field("mem.we", got.mem.we, exp.mem.we);
      check_field("mem.addr", got.mem.addr, exp.mem.addr);
    end
  endtask

  initial begin : responder
    int unsigned dly;
    forever begin
      @(posedge clk);
      if (rst_n && trace_req) begin
        check_record(trace_rec);
        while (ack_hold) @(posedge clk);
        dly = $urandom % (max_delay + 1);
        repeat (dly) @(posedge clk);
        trace_ack <= 1'b1;
        @(posedge clk);
        while (trace_req) @(posedge clk);
        dly = $urandom % (max_delay + 1);
        repeat (dly) @(posedge clk);
        trace_ack <= 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    tb_cycles++;
    if (tb_cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the trace port stopped making progress", tb_cycles);
      $display("sim failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // stimulus tasks

  task automatic issue(input logic [31:0] p, input logic [31:0] ins);
    // id_valid without decode must not issue
    if ($urandom % 4 == 0) begin
      id_valid    <= 1'b1;
      is_decoding <= 1'b0;
      pc          <= $urandom;
      instr       <= $urandom;
      @(posedge clk);
    end
    id_valid    <= 1'b1;
    is_decoding <= 1'b1;
    pc          <= p;
    instr       <= ins;
    @(posedge clk);
    id_valid    <= 1'b0;
    is_decoding <= 1'b0;
  endtask

  task automatic drain(input bit rand_done);
    while (exp_q.size() > 0 || trace_req || trace_ack) begin
      if (rand_done) begin
        ex_valid  <= ($urandom % 3 == 0);
        wb_bypass <= ($urandom % 4 == 0);
        wb_valid  <= ($urandom % 2 == 0);
      end
      @(posedge clk);
    end
    ex_valid  <= 1'b0;
    wb_bypass <= 1'b0;
    wb_valid  <= 1'b0;
  endtask

  // one instruction through both stages, mode 0 plain, 1 register writes, 2 data accesses
  task automatic trace_one(input int mode);
    logic [31:0] ins;
    logic [31:0] p;
    trace_rec_t  r;
    reg_idx_t    rd;
    reg_write_t  w;
    mem_acc_t    m;
    logic        written;
    logic [31:0] value;
    logic        is_mem;
    logic        req;
    logic        gnt;
    logic        dwe;
    logic [31:0] da;
    int          n;
    int          i;
    ins      = $urandom;
    ins[6:0] = pick_opcode($urandom, 7'($urandom));
    // favour loads and stores, indices 5, 6, 10 and 11
    if (mode == 2 && $urandom % 2 == 0) begin
      ins[6:0] = pick_opcode(5 + ($urandom % 2) + 5 * ($urandom % 2), 7'h0);
    end
    if (mode == 1 && $urandom % 5 == 0) begin
      ins[11:7] = '0;
    end
    p = $urandom & 32'hffff_fffc;
    issue(p, ins);
    // past the load into the execute tracker
    repeat (3) @(posedge clk);
    rd      = exp_q[$].rd;
    is_mem  = exp_q[$].cls inside {cls_load, cls_store};
    written = 1'b0;
    value   = '0;
    m       = '0;
    n = 1 + $urandom % 4;
    for (i = 0; i < n; i++) begin
      w.we   = (mode == 1) && ($urandom % 3 != 0);
      w.addr = pick_addr(ins[11:7]);
      w.data = $urandom;
      req    = (mode == 2) && is_mem && ($urandom % 2 == 0);
      gnt    = ($urandom % 2 == 0);
      dwe    = $urandom % 2;
      da     = $urandom;
      apply_write(w, rd, written, value);
      if (req && gnt && !m.valid) begin
        m = '{valid: 1'b1, we: dwe, addr: da};
      end
      ex_wr     <= w;
      data_req  <= req;
      data_gnt  <= gnt;
      data_we   <= dwe;
      data_addr <= da;
      if (i == n - 1) begin
        if ($urandom % 2 == 0) begin
          ex_valid <= 1'b1;
        end else begin
          wb_bypass <= 1'b1;
        end
      end
      @(posedge clk);
    end
    ex_wr     <= '0;
    data_req  <= 1'b0;
    data_gnt  <= 1'b0;
    ex_valid  <= 1'b0;
    wb_bypass <= 1'b0;
    repeat (2) @(posedge clk);
    n = 1 + $urandom % 3;
    for (i = 0; i < n; i++) begin
      w.we   = (mode == 1) && ($urandom % 3 != 0);
      w.addr = pick_addr(ins[11:7]);
      w.data = $urandom;
      apply_write(w, rd, written, value);
      wb_wr    <= w;
      wb_valid <= (i == n - 1);
      @(posedge clk);
    end
    wb_wr    <= '0;
    wb_valid <= 1'b0;
    r = exp_q.pop_back();
    r.rd_written = written;
    r.rd_value   = value;
    r.mem        = m;
    exp_q.push_back(r);
    drain(1'b0);
  endtask

  task automatic end_test(input string name, input int err_before);
    if (errors == err_before) begin
      $display("test %s: ok", name);
      tests_passed++;
    end else begin
      $display("test %s: %0d errors", name, errors - err_before);
      tests_failed++;
    end
  endtask

  ////////////////////////////////////////
  // test sequence

  initial begin : main
    int err0;
    int i;
    int r;
    void'($urandom(32'h7600a524));
    rst_n = 1'b0;
    id_valid = 1'b0;
    is_decoding = 1'b0;
    pc = '0;
    instr = '0;
    ex_valid = 1'b0;
    wb_bypass = 1'b0;
    ex_wr = '0;
    data_req = 1'b0;
    data_gnt = 1'b0;
    data_we = 1'b0;
    data_addr = '0;
    wb_valid = 1'b0;
    wb_wr = '0;
    trace_ack = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    err0 = errors;
    for (i = 0; i < N_CLASS; i++) trace_one(0);
    end_test("classification", err0);

    err0 = errors;
    for (i = 0; i < N_REGW; i++) trace_one(1);
    end_test("register write merging", err0);

    err0 = errors;
    for (i = 0; i < N_MEM; i++) trace_one(2);
    end_test("memory capture", err0);

    // back-to-back issues, slow receiver, odd rounds complete by bypass
    err0 = errors;
    max_delay = 6;
    for (r = 0; r < N_ROUNDS; r++) begin
      for (i = 0; i < BURST; i++) begin
        id_valid    <= 1'b1;
        is_decoding <= 1'b1;
        pc          <= $urandom & 32'hffff_fffc;
        instr       <= {25'($urandom >> 7), pick_opcode($urandom, 7'($urandom))};
        ex_valid    <= (r % 2 == 0);
        wb_bypass   <= (r % 2 == 1);
        wb_valid    <= ($urandom % 2 == 0);
        @(posedge clk);
      end
      id_valid    <= 1'b0;
      is_decoding <= 1'b0;
      drain(1'b1);
      check_field("overflow", overflow, 1'b0);
    end
    max_delay = 2;
    end_test("bursts and back-pressure", err0);

    // receiver held off while issues keep coming
    err0 = errors;
    ack_hold   = 1'b1;
    ovf_mode   = 1'b1;
    first_drop = -1;
    emitted    = 0;
    issue_total = 0;
    ex_valid <= 1'b1;
    wb_valid <= 1'b1;
    for (i = 0; i < OVF_ISSUES; i++) begin
      id_valid    <= 1'b1;
      is_decoding <= 1'b1;
      pc          <= OVF_BASE + 32'(4 * i);
      instr       <= {25'($urandom >> 7), pick_opcode($urandom, 7'($urandom))};
      @(posedge clk);
    end
    id_valid    <= 1'b0;
    is_decoding <= 1'b0;
    repeat (4) @(posedge clk);
    check_field("overflow", overflow, 1'b1);
    if (first_drop < 0) begin
      $display("no dropped issue was seen during the overflow burst");
      errors++;
    end
    ack_hold = 1'b0;
    r = 0;
    while (r < 30) begin
      @(posedge clk);
      r = (trace_req || trace_ack) ? 0 : r + 1;
    end
    ex_valid <= 1'b0;
    wb_valid <= 1'b0;
    check_field("emitted_count", emitted, CAPACITY);
    exp_q.delete();
    ovf_mode = 1'b0;
    end_test("overflow", err0);

    // reset while a record waits on the port with the sticky flag set
    err0 = errors;
    ack_hold = 1'b1;
    ex_valid <= 1'b1;
    wb_valid <= 1'b1;
    issue($urandom & 32'hffff_fffc, $urandom);
    while (!trace_req) @(posedge clk);
    ex_valid <= 1'b0;
    wb_valid <= 1'b0;
    rst_n <= 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_field("trace_req", trace_req, 1'b0);
    check_field("overflow", overflow, 1'b0);
    ack_hold = 1'b0;
    // nothing comes out before an issue
    for (i = 0; i < 20; i++) begin
      is_decoding <= $urandom % 2;
      @(posedge clk);
    end
    is_decoding <= 1'b0;
    trace_one(0);
    end_test("reset behavior", err0);

    $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== verilog/instr_classifier.sv ====
// trace issue stage

`timescale 1ns/1ps

`include "trace_params.svh"

module instr_classifier import trace_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   id_valid,
  input  logic                   is_decoding,
  input  logic [`TRACE_XLEN-1:0] pc,
  input  logic [`TRACE_XLEN-1:0] instr,
  output logic                   push,
  output trace_rec_t             rec
);

  logic [`TRACE_CYC_W-1:0] cycle_q;
  logic                    issue;
  instr_class_e            cls;
  trace_rec_t              rec_d;

  assign issue = id_valid & is_decoding;

  // free running cycle count, zero right after reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cycle_q <= '0;
    end else begin
      cycle_q <= cycle_q + 1'b1;
    end
  end

  ////////////////////////////////////////
  // opcode class
  always_comb begin
    case (instr[6:0])
      `OPC_LUI, `OPC_AUIPC:           cls = cls_upper;
      `OPC_JAL, `OPC_JALR:            cls = cls_jump;
      `OPC_BRANCH:                    cls = cls_branch;
      `OPC_LOAD, `OPC_LOAD_POST:      cls = cls_load;
      `OPC_STORE, `OPC_STORE_POST:    cls = cls_store;
      `OPC_OPIMM:                     cls = cls_alu_imm;
      `OPC_OP:                        cls = cls_alu_reg;
      `OPC_SYSTEM:                    cls = cls_system;
      `OPC_CUSTOM_A, `OPC_CUSTOM_B:   cls = cls_custom;
      default:                        cls = cls_invalid;
    endcase
  end

  // issue record, merge fields start cleared
  always_comb begin
    rec_d       = '0;
    rec_d.pc    = pc;
    rec_d.instr = instr;
    rec_d.cycle = cycle_q;
    rec_d.cls   = cls;
    rec_d.rd    = instr[11:7];
    rec_d.rs1   = instr[19:15];
    rec_d.rs2   = instr[24:20];
    // no destination
    if (cls == cls_branch || cls == cls_store) begin
      rec_d.rd = '0;
    end
    // only these formats read a second source
    if (!(cls inside {cls_branch, cls_store, cls_alu_reg, cls_custom})) begin
      rec_d.rs2 = '0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      push <= 1'b0;
    end else begin
      push <= issue;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      rec <= rec_d;
    end
  end

endmodule

// ==== verilog/stage_tracker.sv ====
// virtual pipeline stage tracker

`timescale 1ns/1ps

`include "trace_params.svh"

module stage_tracker import trace_pkg::*; #(
  parameter bit CAPTURE_MEM = 1'b0
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   in_empty,
  input  trace_rec_t             in_rec,
  output logic                   pop,
  input  logic                   stage_done,
  input  reg_write_t             wr,
  input  logic                   mem_req,
  input  logic                   mem_gnt,
  input  logic                   mem_we,
  input  logic [`TRACE_XLEN-1:0] mem_addr,
  output logic                   out_valid,
  input  logic                   out_ready,
  output trace_rec_t             out_rec
);

  logic       busy;
  logic       done_pend;
  logic       xfer;
  trace_rec_t rec_q;
  trace_rec_t rec_nxt;

  // load only when free
  assign pop       = ~busy & ~in_empty;
  assign out_valid = busy & (stage_done | done_pend);
  assign xfer      = out_valid & out_ready;

  ////////////////////////////////////////
  // merge this cycle's activity
  always_comb begin
    rec_nxt = rec_q;
    // x0 is never written
    if (wr.we && rec_q.rd != '0 && wr.addr == rec_q.rd) begin
      rec_nxt.rd_written = 1'b1;
      rec_nxt.rd_value   = wr.data;
    end
    // first granted access wins
    if (CAPTURE_MEM && mem_req && mem_gnt && !rec_q.mem.valid) begin
      rec_nxt.mem.valid = 1'b1;
      rec_nxt.mem.we    = mem_we;
      rec_nxt.mem.addr  = mem_addr;
    end
  end

  assign out_rec = rec_nxt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      done_pend <= 1'b0;
    end else if (pop) begin
      busy <= 1'b1;
    end else if (xfer) begin
      busy      <= 1'b0;
      done_pend <= 1'b0;
    end else if (busy && stage_done) begin
      // blocked downstream, keep the pulse
      done_pend <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      rec_q <= in_rec;
    end else if (busy) begin
      rec_q <= rec_nxt;
    end
  end

endmodule

// ==== verilog/trace_emitter.sv ====
// four-phase trace output port

`timescale 1ns/1ps

module trace_emitter import trace_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       in_valid,
  output logic       in_ready,
  input  trace_rec_t in_rec,
  input  logic       trace_ack,
  output logic       trace_req,
  output trace_rec_t trace_rec
);

  typedef enum logic [1:0] {
    em_idle,
    em_req,
    em_rel
  } em_state_e;

  em_state_e state;

  assign in_ready  = (state == em_idle);
  assign trace_req = (state == em_req);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= em_idle;
    end else begin
      case (state)
        em_idle: if (in_valid) state <= em_req;
        // ack seen, drop req
        em_req:  if (trace_ack) state <= em_rel;
        // wait for receiver to release ack
        em_rel:  if (!trace_ack) state <= em_idle;
        default: state <= em_idle;
      endcase
    end
  end

  // held stable through the handshake
  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      trace_rec <= in_rec;
    end
  end

endmodule

// ==== verilog/trace_fifo.sv ====
// synchronous record queue

`timescale 1ns/1ps

`include "trace_params.svh"

module trace_fifo import trace_pkg::*; #(
  parameter type payload_t = trace_rec_t,
  parameter int  DEPTH     = `TRACE_QDEPTH
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     push,
  input  payload_t din,
  input  logic     pop,
  output payload_t dout,
  output logic     empty,
  output logic     full
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);
  localparam logic [CW-1:0] FULL_CNT = CW'(DEPTH);

  payload_t        mem [DEPTH];
  logic [AW-1:0]   wr_ptr;
  logic [AW-1:0]   rd_ptr;
  logic [CW-1:0]   count;
  logic            do_push;
  logic            do_pop;

  // wrap at DEPTH, which need not be a power of two
  function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
    if (p == AW'(DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  assign empty   = (count == '0);
  assign full    = (count == FULL_CNT);
  assign do_push = push & ~full;
  assign do_pop  = pop & ~empty;
  assign dout    = mem[rd_ptr];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
  end

endmodule

// ==== verilog/trace_params.svh ====
// instruction trace unit
// widths, queue depth and opcodes

`ifndef TRACE_PARAMS_SVH
`define TRACE_PARAMS_SVH

// datapath widths
`define TRACE_XLEN   32
`define TRACE_REG_W  5
`define TRACE_CYC_W  32

// entries per record queue
`define TRACE_QDEPTH 4

////////////////////////////////////////
// base ISA opcodes
`define OPC_LUI        7'b0110111
`define OPC_AUIPC      7'b0010111
`define OPC_JAL        7'b1101111
`define OPC_JALR       7'b1100111
`define OPC_BRANCH     7'b1100011
`define OPC_LOAD       7'b0000011
`define OPC_STORE      7'b0100011
`define OPC_OPIMM      7'b0010011
`define OPC_OP         7'b0110011
`define OPC_SYSTEM     7'b1110011

////////////////////////////////////////
// core extensions
`define OPC_LOAD_POST  7'b0001011
`define OPC_STORE_POST 7'b0101011
`define OPC_CUSTOM_A   7'b1011011
`define OPC_CUSTOM_B   7'b1010111

`endif

// ==== verilog/trace_pkg.sv ====
// trace record types

`include "trace_params.svh"

package trace_pkg;

  // instruction classes, several opcodes may share one
  typedef enum logic [3:0] {
    cls_upper,
    cls_jump,
    cls_branch,
    cls_load,
    cls_store,
    cls_alu_imm,
    cls_alu_reg,
    cls_system,
    cls_custom,
    cls_invalid
  } instr_class_e;

  typedef logic [`TRACE_REG_W-1:0] reg_idx_t;

  // register file write port of one stage
  typedef struct packed {
    logic                   we;
    reg_idx_t               addr;
    logic [`TRACE_XLEN-1:0] data;
  } reg_write_t;

  // captured data access
  typedef struct packed {
    logic                   valid;
    logic                   we;
    logic [`TRACE_XLEN-1:0] addr;
  } mem_acc_t;

  typedef struct packed {
    logic [`TRACE_XLEN-1:0]  pc;
    logic [`TRACE_XLEN-1:0]  instr;
    logic [`TRACE_CYC_W-1:0] cycle;
    instr_class_e            cls;
    reg_idx_t                rd;
    reg_idx_t                rs1;
    reg_idx_t                rs2;
    logic                    rd_written;
    logic [`TRACE_XLEN-1:0]  rd_value;
    mem_acc_t                mem;
  } trace_rec_t;

endpackage

// ==== verilog/trace_unit_top.sv ====
// instruction trace unit top

`timescale 1ns/1ps

`include "trace_params.svh"

module trace_unit_top import trace_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   id_valid,
  input  logic                   is_decoding,
  input  logic [`TRACE_XLEN-1:0] pc,
  input  logic [`TRACE_XLEN-1:0] instr,
  input  logic                   ex_valid,
  input  logic                   wb_bypass,
  input  reg_write_t             ex_wr,
  input  logic                   data_req,
  input  logic                   data_gnt,
  input  logic                   data_we,
  input  logic [`TRACE_XLEN-1:0] data_addr,
  input  logic                   wb_valid,
  input  reg_write_t             wb_wr,
  input  logic                   trace_ack,
  output logic                   trace_req,
  output trace_rec_t             trace_rec,
  output logic                   overflow
);

  logic       cls_push;
  trace_rec_t cls_rec;
  logic       iq_empty, iq_full, iq_pop;
  trace_rec_t iq_dout;
  logic       wq_empty, wq_full, wq_pop;
  trace_rec_t wq_dout;
  logic       ex_out_valid, wb_out_valid, em_ready;
  trace_rec_t ex_out_rec, wb_out_rec;

  instr_classifier u_cls (
    .clk, .rst_n, .id_valid, .is_decoding, .pc, .instr,
    .push (cls_push),
    .rec  (cls_rec)
  );

  ////////////////////////////////////////
  // issue -> execute
  trace_fifo #(.payload_t(trace_rec_t), .DEPTH(`TRACE_QDEPTH)) issue_q (
    .clk, .rst_n,
    .push (cls_push & ~iq_full), .din (cls_rec),
    .pop  (iq_pop), .dout (iq_dout), .empty (iq_empty), .full (iq_full)
  );

  stage_tracker #(.CAPTURE_MEM(1'b1)) ex_trk (
    .clk, .rst_n,
    .in_empty (iq_empty), .in_rec (iq_dout), .pop (iq_pop),
    .stage_done (ex_valid | wb_bypass), .wr (ex_wr),
    .mem_req (data_req), .mem_gnt (data_gnt), .mem_we (data_we), .mem_addr (data_addr),
    .out_valid (ex_out_valid), .out_ready (~wq_full), .out_rec (ex_out_rec)
  );

  ////////////////////////////////////////
  // execute -> writeback
  trace_fifo #(.payload_t(trace_rec_t), .DEPTH(`TRACE_QDEPTH)) wb_q (
    .clk, .rst_n,
    .push (ex_out_valid & ~wq_full), .din (ex_out_rec),
    .pop  (wq_pop), .dout (wq_dout), .empty (wq_empty), .full (wq_full)
  );

  stage_tracker #(.CAPTURE_MEM(1'b0)) wb_trk (
    .clk, .rst_n,
    .in_empty (wq_empty), .in_rec (wq_dout), .pop (wq_pop),
    .stage_done (wb_valid), .wr (wb_wr),
    .mem_req (1'b0), .mem_gnt (1'b0), .mem_we (1'b0), .mem_addr ('0),
    .out_valid (wb_out_valid), .out_ready (em_ready), .out_rec (wb_out_rec)
  );

  trace_emitter u_emit (
    .clk, .rst_n,
    .in_valid (wb_out_valid), .in_ready (em_ready), .in_rec (wb_out_rec),
    .trace_ack, .trace_req, .trace_rec
  );

  // sticky until reset, a dropped issue
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      overflow <= 1'b0;
    end else if (cls_push && iq_full) begin
      overflow <= 1'b1;
    end
  end

endmodule
